// File: tb.f
+incdir+.
rv_isa_pkg.sv
rv_pipe_pkg.sv
rv_issue_if.sv
rv_fetch.sv
rv_decode.sv
rv_regs.sv
rv_execute.sv
rv_hazard.sv
rv_core.sv
rv_core_assert.sv
tb_core.sv

// File: Makefile
VERILATOR := verilator
TOP       := tb_core
FILELIST  := tb.f
VFLAGS    := --binary --timing --assert --timescale 1ns/1ns --top-module $(TOP)
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SIM_ARGS  := +verilator+error+limit+1000
SRCS      := $(filter-out +incdir+%,$(shell cat $(FILELIST))) rv_defs.svh

.PHONY: run clean

run: $(BIN)
	@out="$$(./$(BIN) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: tb_core.sv
`timescale 1ns/1ns

`include "rv_defs.svh"

module tb_core;
    import rv_isa_pkg::*;

    localparam int          PROG_LEN     = 31;
    localparam int          NUM_TESTS    = 5;
    localparam int          LIMIT_CYCLES = PROG_LEN * 4 + 50;
    localparam logic [31:0] RESULT_BASE  = 32'h100;
    localparam int          CHAIN_SEED   = 37;
    localparam int          LOAD_VAL     = 1234;
    localparam int          ADDEND       = -300;
    localparam int          FLAG_STEP    = 16;
    localparam int          JAL_PC       = 20 * 4;    // JAL sits at word 20.
    localparam logic [19:0] LUI_HI       = 20'hABCDE;
    localparam logic [11:0] ORI_LO       = 12'h123;

    logic                clk;
    logic                rst_n;
    logic                instr_req;
    logic [`RV_XLEN-1:0] instr_addr;
    logic [`RV_XLEN-1:0] instr_data;
    logic                data_req;
    logic                data_write;
    logic [`RV_XLEN-1:0] data_addr;
    logic [`RV_XLEN-1:0] data_wdata;
    logic [`RV_XLEN-1:0] data_rdata;
    logic [31:0]         dmem [256];
    logic [31:0]         expect_val [NUM_TESTS];
    string               test_name [NUM_TESTS];
    int                  pass_count = 0;
    int                  fail_count = 0;
    int                  done_count = 0;

    rv_core UUT
    (
        .i_clk          (clk),
        .i_rst_n        (rst_n),
        .o_instr_req    (instr_req),
        .o_instr_addr   (instr_addr),
        .i_instr_data   (instr_data),
        .o_data_req     (data_req),
        .o_data_write   (data_write),
        .o_data_addr    (data_addr),
        .o_data_wdata   (data_wdata),
        .i_data_rdata   (data_rdata)
    );

    always #2 clk = ~clk;

    // ####################################################################
    // Instruction encoders and program

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input int rd, input int rs1, input int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OPC_OP};
    endfunction

    function automatic logic [31:0] i_type(input logic [6:0] opc, input logic [2:0] f3,
                                           input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
    endfunction

    function automatic logic [31:0] s_type(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] b_type(input logic [2:0] f3, input int rs1, input int rs2,
                                           input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] j_type(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OPC_JAL};
    endfunction

    function automatic logic [31:0] u_type(input int rd, input logic [19:0] imm20);
        return {imm20, rd[4:0], OPC_LUI};
    endfunction

    function automatic logic [31:0] rom_word(input logic [31:0] addr);
        int          idx;
        logic [31:0] w;
        idx = int'(addr >> 2);
        case (idx)
            0:  w = i_type(OPC_OP_IMM, F3_ADD, 1, 0, CHAIN_SEED);
            1:  w = r_type(7'b0000000, F3_ADD, 2, 1, 1);
            2:  w = r_type(7'b0100000, F3_ADD, 3, 1, 2);    // SUB
            3:  w = r_type(7'b0000000, F3_XOR, 4, 3, 2);
            4:  w = r_type(7'b0000000, F3_SLT, 5, 4, 1);
            5:  w = r_type(7'b0000000, F3_SLL, 6, 1, 5);
            6:  w = r_type(7'b0000000, F3_ADD, 7, 6, 4);
            7:  w = s_type(7, 0, 'h100);
            8:  w = i_type(OPC_OP_IMM, F3_ADD, 8, 0, LOAD_VAL);
            9:  w = i_type(OPC_OP_IMM, F3_ADD, 11, 0, ADDEND);
            10: w = s_type(8, 0, 'h200);
            11: w = i_type(OPC_LOAD, 3'b010, 9, 0, 'h200);
            12: w = r_type(7'b0000000, F3_ADD, 10, 9, 11);  // Uses the load at once.
            13: w = s_type(10, 0, 'h104);
            14: w = i_type(OPC_OP_IMM, F3_ADD, 13, 0, 5);
            15: w = b_type(F3_BEQ, 13, 13, 12);
            16: w = i_type(OPC_OP_IMM, F3_ADD, 12, 12, 1);
            17: w = i_type(OPC_OP_IMM, F3_ADD, 12, 12, 2);
            18: w = b_type(F3_BNE, 13, 13, 8);
            19: w = i_type(OPC_OP_IMM, F3_ADD, 12, 12, FLAG_STEP);
            20: w = j_type(14, 12);
            21: w = i_type(OPC_OP_IMM, F3_ADD, 12, 12, 4);
            22: w = i_type(OPC_OP_IMM, F3_ADD, 12, 12, 8);
            23: w = r_type(7'b0000000, F3_ADD, 15, 12, 14);
            24: w = s_type(15, 0, 'h108);
            25: w = i_type(OPC_OP_IMM, F3_ADD, 0, 0, 77);
            26: w = s_type(0, 0, 'h10C);
            27: w = u_type(16, LUI_HI);
            28: w = i_type(OPC_OP_IMM, F3_OR, 16, 16, int'(ORI_LO));
            29: w = s_type(16, 0, 'h110);
            30: w = j_type(0, 0);                            // Park here.
            default: w = `RV_NOP;
        endcase
        return w;
    endfunction

    // ####################################################################
    // Expected results and checks

    task automatic build_expected();
        logic [31:0] a1;
        logic [31:0] a2;
        logic [31:0] a3;
        logic [31:0] a4;
        logic [31:0] a5;
        logic [31:0] a6;
        a1 = 32'(CHAIN_SEED);
        a2 = a1 + a1;
        a3 = a1 - a2;
        a4 = a3 ^ a2;
        a5 = ($signed(a4) < $signed(a1)) ? 32'd1 : 32'd0;
        a6 = a1 << a5[4:0];
        test_name[0]  = "alu_chain";
        expect_val[0] = a6 + a4;
        test_name[1]  = "load_use";
        expect_val[1] = 32'(LOAD_VAL + ADDEND);
        test_name[2]  = "control_flow";
        expect_val[2] = 32'(FLAG_STEP) + 32'(JAL_PC + 4);  // Only the BNE fall-through counts.
        test_name[3]  = "x0_write";
        expect_val[3] = 32'd0;
        test_name[4]  = "lui_ori";
        expect_val[4] = {LUI_HI, 12'h000} | {20'h00000, ORI_LO};
    endtask

    task automatic check_result(input int idx, input logic [31:0] actual);
        done_count++;
        assert (actual === expect_val[idx])
        begin
            pass_count++;
            $display("[PASS]  %s: 0x%08h", test_name[idx], actual);
        end
        else
        begin
            fail_count++;
            $display("[ERROR] %s: expected 0x%08h, actual 0x%08h",
                     test_name[idx], expect_val[idx], actual);
        end
    endtask

    // Both memories answer one cycle after the request.
    always @(posedge clk)
    begin
        if (instr_req)
            instr_data <= rom_word(instr_addr);
        if (data_req && !data_write)
            data_rdata <= dmem[data_addr[9:2]];
        if (data_req && data_write)
        begin
            dmem[data_addr[9:2]] <= data_wdata;
            if (data_addr >= RESULT_BASE && data_addr < RESULT_BASE + 4 * NUM_TESTS)
                check_result(int'((data_addr - RESULT_BASE) >> 2), data_wdata);
        end
    end

    initial
    begin
        repeat (LIMIT_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles with %0d of %0d results stored",
                 LIMIT_CYCLES, done_count, NUM_TESTS);
        $display("Test FAILED");
        $finish;
    end

    initial
    begin
        clk        = 1'b0;
        rst_n      <= 1'b0;
        instr_data <= `RV_NOP;
        data_rdata <= '0;
        for (int i = 0; i < 256; i++)
            dmem[i] <= '0;
        build_expected();
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        wait (done_count == NUM_TESTS);
        repeat (4) @(posedge clk);
        $display("Results: %0d passed, %0d failed, %0d bus assertion failures",
                 pass_count, fail_count, UUT.bus_checks.error_total);
        if (fail_count == 0 && UUT.bus_checks.error_total == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

// File: rv_core_assert.sv
`timescale 1ns/1ns

`include "rv_defs.svh"

module rv_core_assert
(
    input logic               i_clk,
    input logic               i_rst_n,
    input logic               i_instr_req,
    input rv_pipe_pkg::word_t i_instr_addr,
    input logic               i_data_req,
    input logic               i_data_write,
    input rv_pipe_pkg::word_t i_data_addr,
    input logic               i_redirect,
    input logic               i_stall
);
    int reset_fails = 0;
    int boot_fails  = 0;
    int step_fails  = 0;
    int align_fails = 0;
    int error_total;

    assign error_total = reset_fails + boot_fails + step_fails + align_fails;

    // ####################################################################
    // Bus rules

    assert property (@(posedge i_clk) !i_rst_n |-> !i_instr_req && !i_data_req && !i_data_write)
    else
    begin
        $error("bus request active while reset is held");
        reset_fails++;
    end

    assert property (@(posedge i_clk) disable iff (!i_rst_n)
                     $rose(i_instr_req) |-> i_instr_addr == `RV_RESET_ADDR)
    else
    begin
        $error("first fetch address is 0x%08h", i_instr_addr);
        boot_fails++;
    end

    // Without a stall or redirect the fetch stream moves on by one word.
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
                     i_instr_req && $past(i_instr_req) && !$past(i_redirect) && !$past(i_stall)
                     |-> i_instr_addr == $past(i_instr_addr) + 32'd4)
    else
    begin
        $error("fetch address 0x%08h does not follow the previous one", i_instr_addr);
        step_fails++;
    end

    assert property (@(posedge i_clk) disable iff (!i_rst_n)
                     i_data_req |-> i_data_addr[1:0] == 2'b00)
    else
    begin
        $error("misaligned data address 0x%08h", i_data_addr);
        align_fails++;
    end

endmodule

bind rv_core rv_core_assert bus_checks
(
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_instr_req    (o_instr_req),
    .i_instr_addr   (o_instr_addr),
    .i_data_req     (o_data_req),
    .i_data_write   (o_data_write),
    .i_data_addr    (o_data_addr),
    .i_redirect     (redirect),
    .i_stall        (stall)
);

// File: rv_core.sv
`timescale 1ns/1ns

module rv_core
(
    input  logic               i_clk,
    input  logic               i_rst_n,
    output logic               o_instr_req,
    output rv_pipe_pkg::word_t o_instr_addr,
    input  rv_pipe_pkg::word_t i_instr_data,
    output logic               o_data_req,
    output logic               o_data_write,
    output rv_pipe_pkg::word_t o_data_addr,
    output rv_pipe_pkg::word_t o_data_wdata,
    input  rv_pipe_pkg::word_t i_data_rdata
);
    import rv_pipe_pkg::*;

    logic     stall;
    logic     flush;
    logic     redirect;
    word_t    redirect_pc;
    word_t    fetch_pc;
    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    word_t    rs1_val;
    word_t    rs2_val;
    reg_idx_t wb_rd;
    word_t    wb_data;
    logic     wb_we;

    rv_issue_if issue ();

    rv_fetch u_fetch
    (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_stall        (stall),
        .i_redirect     (redirect),
        .i_redirect_pc  (redirect_pc),
        .o_instr_req    (o_instr_req),
        .o_instr_addr   (o_instr_addr),
        .o_pc           (fetch_pc)
    );

    rv_decode u_decode
    (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_stall        (stall),
        .i_flush        (flush),
        .i_instr        (i_instr_data),
        .i_pc           (fetch_pc),
        .o_rs1_idx      (rs1_idx),
        .o_rs2_idx      (rs2_idx),
        .i_rs1_val      (rs1_val),
        .i_rs2_val      (rs2_val),
        .issue          (issue.decode)
    );

    rv_regs u_regs
    (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_rs1_idx      (rs1_idx),
        .i_rs2_idx      (rs2_idx),
        .o_rs1_val      (rs1_val),
        .o_rs2_val      (rs2_val),
        .i_wb_rd        (wb_rd),
        .i_wb_data      (wb_data),
        .i_wb_we        (wb_we)
    );

    rv_execute u_execute
    (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .issue          (issue.execute),
        .i_load_data    (i_data_rdata),
        .o_data_req     (o_data_req),
        .o_data_write   (o_data_write),
        .o_data_addr    (o_data_addr),
        .o_data_wdata   (o_data_wdata),
        .o_redirect     (redirect),
        .o_redirect_pc  (redirect_pc),
        .o_wb_rd        (wb_rd),
        .o_wb_data      (wb_data),
        .o_wb_we        (wb_we)
    );

    rv_hazard u_hazard
    (
        .i_decode_rs1   (rs1_idx),
        .i_decode_rs2   (rs2_idx),
        .issue          (issue.hazard),
        .i_redirect     (redirect),
        .o_stall        (stall),
        .o_flush        (flush)
    );

endmodule

// File: rv_hazard.sv
`timescale 1ns/1ns

module rv_hazard
(
    input  rv_pipe_pkg::reg_idx_t i_decode_rs1,
    input  rv_pipe_pkg::reg_idx_t i_decode_rs2,
    rv_issue_if.hazard            issue,
    input  logic                  i_redirect,
    output logic                  o_stall,
    output logic                  o_flush
);
    import rv_pipe_pkg::*;

    logic load_use;

    // The loaded word reaches the register file only in writeback.
    assign load_use = (issue.res_src == RES_LOAD) && (issue.rd != '0)
                      && ((issue.rd == i_decode_rs1) || (issue.rd == i_decode_rs2));

    // A redirect discards the word in decode, so a pending stall is pointless.
    assign o_stall = load_use && !i_redirect;
    assign o_flush = i_redirect;

endmodule

// File: rv_execute.sv
`timescale 1ns/1ns

module rv_execute
(
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    rv_issue_if.execute           issue,
    input  rv_pipe_pkg::word_t    i_load_data,
    output logic                  o_data_req,
    output logic                  o_data_write,
    output rv_pipe_pkg::word_t    o_data_addr,
    output rv_pipe_pkg::word_t    o_data_wdata,
    output logic                  o_redirect,
    output rv_pipe_pkg::word_t    o_redirect_pc,
    output rv_pipe_pkg::reg_idx_t o_wb_rd,
    output rv_pipe_pkg::word_t    o_wb_data,
    output logic                  o_wb_we
);
    import rv_pipe_pkg::*;

    fwd_src_t fwd_a;
    fwd_src_t fwd_b;
    word_t    rs1_fwd;
    word_t    rs2_fwd;
    word_t    op_b;
    word_t    alu_y;
    word_t    link_pc;
    res_src_t wb_src_q;
    word_t    wb_val_q;

    // ####################################################################
    // Operand forwarding and ALU

    assign fwd_a   = (o_wb_we && o_wb_rd == issue.rs1) ? FWD_WB : FWD_REG;
    assign fwd_b   = (o_wb_we && o_wb_rd == issue.rs2) ? FWD_WB : FWD_REG;
    assign rs1_fwd = (fwd_a == FWD_WB) ? o_wb_data : issue.rs1_val;
    assign rs2_fwd = (fwd_b == FWD_WB) ? o_wb_data : issue.rs2_val;
    assign op_b    = issue.use_imm ? issue.imm : rs2_fwd;

    always_comb
    begin
        alu_y = '0;
        case (issue.alu_op)
            ALU_ADD:    alu_y = rs1_fwd + op_b;
            ALU_SUB:    alu_y = rs1_fwd - op_b;
            ALU_AND:    alu_y = rs1_fwd & op_b;
            ALU_OR:     alu_y = rs1_fwd | op_b;
            ALU_XOR:    alu_y = rs1_fwd ^ op_b;
            ALU_SLT:    alu_y[0] = $signed(rs1_fwd) < $signed(op_b);
            ALU_SLL:    alu_y = rs1_fwd << op_b[4:0];
            ALU_SRL:    alu_y = rs1_fwd >> op_b[4:0];
            default:    alu_y = op_b;
        endcase
    end

    // Branches compare the raw register operands, never the immediate.
    assign o_redirect    = issue.is_jal
                           || (issue.is_branch && ((rs1_fwd == rs2_fwd) != issue.branch_ne));
    assign o_redirect_pc = issue.pc + issue.imm;
    assign link_pc       = issue.pc + word_t'(4);

    assign o_data_req   = issue.is_store || (issue.res_src == RES_LOAD);
    assign o_data_write = issue.is_store;
    assign o_data_addr  = alu_y;
    assign o_data_wdata = rs2_fwd;

    // ####################################################################
    // Writeback register

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_wb_rd  <= '0;
            wb_src_q <= RES_NONE;
        end
        else
        begin
            o_wb_rd  <= issue.rd;
            wb_src_q <= issue.res_src;
        end
    end

    always_ff @(posedge i_clk)
    begin
        wb_val_q <= (issue.res_src == RES_LINK) ? link_pc : alu_y;
    end

    assign o_wb_we   = (wb_src_q != RES_NONE) && (o_wb_rd != '0);
    assign o_wb_data = (wb_src_q == RES_LOAD) ? i_load_data : wb_val_q; // Load data is late.

endmodule

// File: rv_regs.sv
`timescale 1ns/1ns

`include "rv_defs.svh"

module rv_regs
(
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  rv_pipe_pkg::reg_idx_t i_rs1_idx,
    input  rv_pipe_pkg::reg_idx_t i_rs2_idx,
    output rv_pipe_pkg::word_t    o_rs1_val,
    output rv_pipe_pkg::word_t    o_rs2_val,
    input  rv_pipe_pkg::reg_idx_t i_wb_rd,
    input  rv_pipe_pkg::word_t    i_wb_data,
    input  logic                  i_wb_we
);
    import rv_pipe_pkg::*;

    word_t regs_q [`RV_REG_COUNT];

    // x0 reads zero, and a register being written reads its new value.
    function automatic word_t read_port(input reg_idx_t idx);
        word_t val;
        if (idx == '0)
            val = '0;
        else if (i_wb_we && idx == i_wb_rd)
            val = i_wb_data;
        else
            val = regs_q[idx];
        return val;
    endfunction

    always_comb
    begin
        o_rs1_val = read_port(i_rs1_idx);
        o_rs2_val = read_port(i_rs2_idx);
    end

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            for (int i = 0; i < `RV_REG_COUNT; i++)
                regs_q[i] <= '0;
        end
        else if (i_wb_we && i_wb_rd != '0)
        begin
            regs_q[i_wb_rd] <= i_wb_data;
        end
    end

endmodule

// File: rv_decode.sv
`timescale 1ns/1ns

`include "rv_defs.svh"

module rv_decode
(
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_stall,
    input  logic                  i_flush,
    input  rv_pipe_pkg::word_t    i_instr,
    input  rv_pipe_pkg::word_t    i_pc,
    output rv_pipe_pkg::reg_idx_t o_rs1_idx,
    output rv_pipe_pkg::reg_idx_t o_rs2_idx,
    input  rv_pipe_pkg::word_t    i_rs1_val,
    input  rv_pipe_pkg::word_t    i_rs2_val,
    rv_issue_if.decode            issue
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    logic        boot_q;
    logic        drop_q;
    logic        replay_q;
    word_t       held_instr;
    word_t       held_pc;
    word_t       cur_instr;
    word_t       cur_pc;
    word_t       word;
    opcode_t     opcode;
    funct3_alu_t f3_alu;
    funct3_br_t  f3_br;
    logic [6:0]  funct7;
    alu_op_t     alu_op;
    res_src_t    res_src;
    word_t       imm;
    logic        use_imm;
    logic        is_store;
    logic        is_branch;
    logic        is_jal;
    logic        branch_ne;

    // ####################################################################
    // Selection of the word in decode

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            boot_q   <= 1'b1;
            drop_q   <= 1'b1;
            replay_q <= 1'b0;
        end
        else
        begin
            boot_q   <= 1'b0;
            drop_q   <= i_flush || boot_q;    // Words fetched before a redirect are stale.
            replay_q <= i_stall;
        end
    end

    // A stalled word is already gone from the bus, so keep a copy for the next cycle.
    always_ff @(posedge i_clk)
    begin
        if (i_stall)
        begin
            held_instr <= cur_instr;
            held_pc    <= cur_pc;
        end
    end

    assign cur_instr = drop_q ? `RV_NOP : (replay_q ? held_instr : i_instr);
    assign cur_pc    = replay_q ? held_pc : i_pc;
    assign o_rs1_idx = cur_instr[19:15];
    assign o_rs2_idx = cur_instr[24:20];

    assign word   = (i_flush || i_stall) ? `RV_NOP : cur_instr;  // Bubble into execute.
    assign opcode = opcode_t'(word[6:0]);
    assign f3_alu = funct3_alu_t'(word[14:12]);
    assign f3_br  = funct3_br_t'(word[14:12]);
    assign funct7 = word[31:25];

    // ####################################################################
    // Instruction decoding

    always_comb
    begin
        alu_op    = ALU_ADD;
        res_src   = RES_NONE;
        imm       = {{20{word[31]}}, word[31:20]};
        use_imm   = 1'b1;
        is_store  = 1'b0;
        is_branch = 1'b0;
        is_jal    = 1'b0;
        branch_ne = 1'b0;
        case (opcode)
            OPC_OP:
            begin
                use_imm = 1'b0;
                if (funct7 == 7'b0000000 || (funct7 == 7'b0100000 && f3_alu == F3_ADD))
                begin
                    res_src = RES_ALU;
                    case (f3_alu)
                        F3_ADD:  alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
                        F3_SLL:  alu_op = ALU_SLL;
                        F3_SLT:  alu_op = ALU_SLT;
                        F3_XOR:  alu_op = ALU_XOR;
                        F3_SRL:  alu_op = ALU_SRL;
                        F3_OR:   alu_op = ALU_OR;
                        F3_AND:  alu_op = ALU_AND;
                        default: res_src = RES_NONE;
                    endcase
                end
            end
            OPC_OP_IMM:
            begin
                res_src = RES_ALU;
                case (f3_alu)
                    F3_ADD:  alu_op = ALU_ADD;
                    F3_SLT:  alu_op = ALU_SLT;
                    F3_XOR:  alu_op = ALU_XOR;
                    F3_OR:   alu_op = ALU_OR;
                    F3_AND:  alu_op = ALU_AND;
                    default: res_src = RES_NONE;   // No immediate shifts here.
                endcase
            end
            OPC_LUI:
            begin
                alu_op  = ALU_PASS_B;
                res_src = RES_ALU;
                imm     = {word[31:12], 12'b0};
            end
            OPC_BRANCH:
            begin
                use_imm   = 1'b0;
                imm       = {{19{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
                is_branch = (f3_br == F3_BEQ) || (f3_br == F3_BNE);
                branch_ne = (f3_br == F3_BNE);
            end
            OPC_JAL:
            begin
                is_jal  = 1'b1;
                res_src = RES_LINK;
                imm     = {{11{word[31]}}, word[31], word[19:12], word[20], word[30:21], 1'b0};
            end
            OPC_LOAD:
            begin
                if (word[14:12] == 3'b010)
                    res_src = RES_LOAD;
            end
            OPC_STORE:
            begin
                imm      = {{20{word[31]}}, word[31:25], word[11:7]};
                is_store = (word[14:12] == 3'b010);    // Word stores only.
            end
            default:
            begin
                res_src = RES_NONE;
            end
        endcase
    end

    // ####################################################################
    // Decode/execute register

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            issue.rd        <= '0;
            issue.alu_op    <= ALU_ADD;
            issue.res_src   <= RES_NONE;
            issue.use_imm   <= 1'b0;
            issue.is_store  <= 1'b0;
            issue.is_branch <= 1'b0;
            issue.is_jal    <= 1'b0;
            issue.branch_ne <= 1'b0;
        end
        else
        begin
            issue.rd        <= word[11:7];
            issue.alu_op    <= alu_op;
            issue.res_src   <= res_src;
            issue.use_imm   <= use_imm;
            issue.is_store  <= is_store;
            issue.is_branch <= is_branch;
            issue.is_jal    <= is_jal;
            issue.branch_ne <= branch_ne;
        end
    end

    always_ff @(posedge i_clk)
    begin
        issue.pc      <= cur_pc;
        issue.rs1     <= word[19:15];
        issue.rs2     <= word[24:20];
        issue.rs1_val <= i_rs1_val;
        issue.rs2_val <= i_rs2_val;
        issue.imm     <= imm;
    end

endmodule

// File: rv_fetch.sv
`timescale 1ns/1ns

`include "rv_defs.svh"

module rv_fetch
(
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               i_stall,
    input  logic               i_redirect,
    input  rv_pipe_pkg::word_t i_redirect_pc,
    output logic               o_instr_req,
    output rv_pipe_pkg::word_t o_instr_addr,
    output rv_pipe_pkg::word_t o_pc
);
    import rv_pipe_pkg::*;

    word_t pc_next;

    always_comb
    begin
        if (i_redirect)
            pc_next = i_redirect_pc;
        else if (i_stall || !o_instr_req)
            pc_next = o_instr_addr;    // Hold, or wait for the first request.
        else
            pc_next = o_instr_addr + word_t'(4);
    end

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_instr_req  <= 1'b0;
            o_instr_addr <= `RV_RESET_ADDR;
        end
        else
        begin
            o_instr_req  <= 1'b1;
            o_instr_addr <= pc_next;
        end
    end

    // The memory answers one cycle late, so the last address belongs to the arriving word.
    always_ff @(posedge i_clk)
    begin
        o_pc <= o_instr_addr;
    end

endmodule

// File: rv_issue_if.sv
`timescale 1ns/1ns

interface rv_issue_if;
    import rv_pipe_pkg::*;

    word_t    pc;
    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    rs1_val;
    word_t    rs2_val;
    reg_idx_t rd;
    word_t    imm;
    alu_op_t  alu_op;
    res_src_t res_src;
    logic     use_imm;
    logic     is_store;
    logic     is_branch;
    logic     is_jal;
    logic     branch_ne;

    modport decode (output pc, rs1, rs2, rs1_val, rs2_val, rd, imm, alu_op, res_src,
                    use_imm, is_store, is_branch, is_jal, branch_ne);
    modport execute (input pc, rs1, rs2, rs1_val, rs2_val, rd, imm, alu_op, res_src,
                     use_imm, is_store, is_branch, is_jal, branch_ne);
    modport hazard (input rd, res_src);

endinterface

// File: rv_pipe_pkg.sv
`include "rv_defs.svh"

package rv_pipe_pkg;

    typedef logic [`RV_XLEN-1:0]               word_t;
    typedef logic [$clog2(`RV_REG_COUNT)-1:0]  reg_idx_t;

    typedef enum logic [3:0]
    {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_PASS_B      // Operand b straight through, used by LUI.
    } alu_op_t;

    typedef enum logic [1:0] {RES_NONE, RES_ALU, RES_LOAD, RES_LINK} res_src_t;

    typedef enum logic {FWD_REG, FWD_WB} fwd_src_t;

endpackage

// File: rv_isa_pkg.sv
package rv_isa_pkg;

    typedef enum logic [6:0]
    {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011
    } opcode_t;

    typedef enum logic [2:0]
    {
        F3_ADD = 3'b000,    // Also SUB, told apart by funct7.
        F3_SLL = 3'b001,
        F3_SLT = 3'b010,
        F3_XOR = 3'b100,
        F3_SRL = 3'b101,
        F3_OR  = 3'b110,
        F3_AND = 3'b111
    } funct3_alu_t;

    typedef enum logic [2:0]
    {
        F3_BEQ = 3'b000,
        F3_BNE = 3'b001
    } funct3_br_t;

endpackage

// File: rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// Machine word width, shared by data and addresses.
`define RV_XLEN         32

`define RV_RESET_ADDR   32'h0000_0000   // First address fetched after reset.

`define RV_REG_COUNT    32              // Architectural integer registers.

// ADDI x0, x0, 0 is the canonical no-op.
`define RV_NOP          32'h0000_0013

`endif
